/* rtl/irPkg.sv */
`default_nettype none

package irPkg;

  // Field widths fixed by the instruction format
  localparam int IrWidth       = 13;
  localparam int AdWidth       = 36;
  localparam int DramAddrWidth = 9;
  localparam int DramDepth     = 512;
  localparam int DramWidth     = 15;
  localparam int DiagWidth     = 6;
  localparam int DiagSelWidth  = 3;

  // JRST is 254 octal
  localparam logic [0:8] JrstOpcode = 9'o254;
  localparam logic [0:2] IoPrefix   = 3'b111;

  // First bit of each field in the [0:14] dispatch word
  localparam int DramPosA     = 0;
  localparam int DramPosB     = 3;
  localparam int DramPosPar   = 6;
  localparam int DramPosJHigh = 7;
  localparam int DramPosJLow  = 11;

  typedef struct packed {
    logic [0:8] opcode;
    logic [0:3] ac;
  } irOpT;

  typedef struct packed {
    logic [0:2] prefix;
    logic [0:6] device;
    logic [0:2] func;
  } irIoT;

  // Same 13 bits seen as opcode/AC or as I/O device/function
  typedef union packed {
    irOpT op;
    irIoT io;
  } irWordT;

endpackage

`default_nettype wire

/* rtl/dramMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dramMem (
  input  logic                            eboxClk,
  input  logic [0:irPkg::DramAddrWidth-1] rdAddr,
  input  logic                            rdEn,
  output logic [0:irPkg::DramWidth-1]     rdData,
  input  logic                            wrEn,
  input  logic [0:irPkg::DramAddrWidth-1] wrAddr,
  input  logic [0:irPkg::DramWidth-1]     wrData
);
  import irPkg::*;

  logic [0:DramWidth-1] mem [0:DramDepth-1];

  // Loaded through the diagnostic path only
  always_ff @(posedge eboxClk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Registered read that holds while rdEn is low
  always_ff @(posedge eboxClk) begin
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

/* rtl/irLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module irLatch (
  input  logic                          eboxClk,
  input  logic                          arstN,
  input  logic                          instValid,
  input  logic [0:irPkg::IrWidth-1]     instWord,
  output logic                          instReady,
  output logic                          irValid,
  input  logic                          irReady,
  output irPkg::irWordT                 irWord,
  output logic                          jrst,
  output logic                          jrst0,
  output logic                          ioLegal,
  output logic                          acEq0,
  output logic [0:3]                    irAc,
  input  logic                          diagCtlWe,
  input  logic [0:1]                    diagCtlData,
  output logic                          enIoJrst,
  output logic                          enAc
);
  import irPkg::*;

  logic instAccept;

  // Room when empty or when the held item moves on this cycle
  assign instReady  = ~irValid | irReady;
  assign instAccept = instValid & instReady;

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      irValid <= 1'b0;
    end else if (instAccept) begin
      irValid <= 1'b1;
    end else if (irReady) begin
      irValid <= 1'b0;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (instAccept) begin
      irWord <= instWord;
    end
  end

  // Diagnostic control bits with bit 0 as the I/O dispatch enable
  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      enIoJrst <= 1'b0;
      enAc     <= 1'b0;
    end else if (diagCtlWe) begin
      enIoJrst <= diagCtlData[0];
      enAc     <= diagCtlData[1];
    end
  end

  // Field decodes off the latched word
  assign jrst    = irWord.op.opcode == JrstOpcode;
  assign acEq0   = irWord.op.ac == 4'b0000;
  assign jrst0   = jrst & acEq0;
  assign ioLegal = &irWord.op.opcode[3:6];

  // AC only reaches the AC mixers when enabled
  assign irAc = enAc ? irWord.op.ac : 4'b0000;

endmodule

`default_nettype wire

/* rtl/dramDispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dramDispatch (
  input  logic                                eboxClk,
  input  logic                                arstN,
  input  logic                                irValid,
  output logic                                irReady,
  input  irPkg::irWordT                       irWord,
  input  logic                                jrst,
  input  logic                                enIoJrst,
  output logic                                dispValid,
  input  logic                                dispReady,
  output logic [0:2]                          dispA,
  output logic [0:2]                          dispB,
  output logic [0:3]                          dispJHigh,
  output logic [0:3]                          dispJLow,
  output logic                                dispParityWord,
  output logic                                dispParityOk,
  output logic [0:irPkg::DramAddrWidth-1]     dramAddr,
  input  logic                                diagWrEn,
  input  logic [0:irPkg::DramAddrWidth-1]     diagWrAddr,
  input  logic [0:irPkg::DramWidth-1]         diagWrData
);
  import irPkg::*;

  logic                     ioDispatch;
  logic                     devAllOnes;
  logic [0:2]               devTop;
  logic [0:DramAddrWidth-1] nextAddr;
  logic                     irAccept;
  logic [0:DramWidth-1]     ramWord;
  logic                     jrstQ;
  logic [0:3]               acQ;

  // I/O instructions dispatch on device and function
  assign ioDispatch = (irWord.io.prefix == IoPrefix) & enIoJrst;
  assign devAllOnes = &irWord.io.device[3:6];
  assign devTop     = devAllOnes ? 3'b111 : irWord.io.device[0:2];
  assign nextAddr   = ioDispatch ? {irWord.io.prefix, devTop, irWord.io.func}
                                 : irWord.op.opcode;

  // RAM port is busy during diagnostic writes
  assign irReady  = (~dispValid | dispReady) & ~diagWrEn;
  assign irAccept = irValid & irReady;

  // Read register of the RAM doubles as the output register
  dramMem mem_i (
    .eboxClk (eboxClk),
    .rdAddr  (nextAddr),
    .rdEn    (irAccept),
    .rdData  (ramWord),
    .wrEn    (diagWrEn),
    .wrAddr  (diagWrAddr),
    .wrData  (diagWrData)
  );

  always_ff @(posedge eboxClk or negedge arstN) begin
    if (!arstN) begin
      dispValid <= 1'b0;
    end else if (irAccept) begin
      dispValid <= 1'b1;
    end else if (dispReady) begin
      dispValid <= 1'b0;
    end
  end

  // Side info that travels with the RAM word
  always_ff @(posedge eboxClk) begin
    if (irAccept) begin
      dramAddr <= nextAddr;
      jrstQ    <= jrst;
      acQ      <= irWord.op.ac;
    end
  end

  assign dispA          = ramWord[DramPosA +: 3];
  assign dispB          = ramWord[DramPosB +: 3];
  assign dispJHigh      = ramWord[DramPosJHigh +: 4];
  assign dispParityWord = ramWord[DramPosPar];

  // JRST dispatches on its AC field
  assign dispJLow = jrstQ ? acQ : ramWord[DramPosJLow +: 4];

  // Good words carry odd parity over all 15 bits
  assign dispParityOk = ^ramWord;

endmodule

`default_nettype wire

/* rtl/condTest.sv */
`timescale 1ns/1ps
`default_nettype none

module condTest (
  input  logic [0:irPkg::AdWidth-1] adData,
  input  logic                      adCarry,
  input  logic                      magicGt,
  input  logic                      magicLt,
  input  logic [0:2]                dispB,
  output logic                      adEq0,
  output logic                      testSatisfied,
  output logic [0:2]                norm
);

  logic greater;
  logic testTerms;

  assign adEq0   = ~|adData;
  // Sign corrected by the carry out
  assign greater = adData[0] ^ adCarry;

  // B field picks the tests and B bit 0 inverts the sense
  assign testTerms = |{dispB[1] & adEq0,
                       dispB[2] & greater & magicGt,
                       dispB[2] & adData[0] & magicLt,
                       adCarry & (magicGt == magicLt)};

  assign testSatisfied = testTerms ^ dispB[0];

  // Normalize shift priority
  always_comb begin
    if (adData[0]) begin
      norm = 3'd1;
    end else if (|adData[1:6]) begin
      norm = 3'd2;
    end else if (adData[7]) begin
      norm = 3'd3;
    end else if (adData[8]) begin
      norm = 3'd4;
    end else if (adData[9]) begin
      norm = 3'd5;
    end else if (adData[10]) begin
      norm = 3'd6;
    end else begin
      // Anything further down only says nonzero
      norm = {2'b00, |adData[11:35]};
    end
  end

endmodule

`default_nettype wire

/* rtl/diagRead.sv */
`timescale 1ns/1ps
`default_nettype none

module diagRead (
  input  logic [0:irPkg::DiagSelWidth-1]  diagSel,
  input  logic [0:2]                      norm,
  input  logic [0:irPkg::DramAddrWidth-1] dramAddr,
  input  logic                            enIoJrst,
  input  logic                            enAc,
  input  logic [0:3]                      irAc,
  input  logic [0:2]                      dispA,
  input  logic [0:2]                      dispB,
  input  logic                            testSatisfied,
  input  logic                            jrst0,
  input  logic [0:3]                      dispJHigh,
  input  logic                            dispParityWord,
  input  logic                            dispParityOk,
  input  logic [0:3]                      dispJLow,
  input  logic                            adEq0,
  input  logic                            ioLegal,
  input  logic                            acEq0,
  input  logic                            adCarry,
  input  logic                            magicGt,
  input  logic                            magicLt,
  input  irPkg::irWordT                   irWord,
  output logic [0:irPkg::DiagWidth-1]     diagRdData
);

  // One six-bit group per select code
  always_comb begin
    case (diagSel)
      3'd0: diagRdData = {norm, dramAddr[0:2]};
      3'd1: diagRdData = dramAddr[3:8];
      3'd2: diagRdData = {enIoJrst, enAc, irAc};
      3'd3: diagRdData = {dispA, dispB};
      3'd4: diagRdData = {testSatisfied, jrst0, dispJHigh};
      3'd5: diagRdData = {dispParityWord, dispParityOk, dispJLow};
      3'd6: diagRdData = {adEq0, ioLegal, acEq0, adCarry, magicGt, magicLt};
      3'd7: diagRdData = irWord.op.opcode[0:5];
    endcase
  end

endmodule

`default_nettype wire

/* rtl/irBoard.sv */
`timescale 1ns/1ps
`default_nettype none

module irBoard (
  input  logic                            eboxClk,
  input  logic                            arstN,
  input  logic                            instValid,
  input  logic [0:irPkg::IrWidth-1]       instWord,
  output logic                            instReady,
  output logic                            dispValid,
  input  logic                            dispReady,
  output logic [0:2]                      dispA,
  output logic [0:2]                      dispB,
  output logic [0:3]                      dispJHigh,
  output logic [0:3]                      dispJLow,
  output logic                            dispParityOk,
  input  logic [0:irPkg::AdWidth-1]       adData,
  input  logic                            adCarry,
  input  logic                            magicGt,
  input  logic                            magicLt,
  output logic [0:3]                      irAc,
  output logic                            ioLegal,
  output logic                            acEq0,
  output logic                            jrst0,
  output logic                            adEq0,
  output logic                            testSatisfied,
  output logic [0:2]                      norm,
  input  logic                            diagWrEn,
  input  logic [0:irPkg::DramAddrWidth-1] diagWrAddr,
  input  logic [0:irPkg::DramWidth-1]     diagWrData,
  input  logic                            diagCtlWe,
  input  logic [0:1]                      diagCtlData,
  input  logic [0:irPkg::DiagSelWidth-1]  diagSel,
  output logic [0:irPkg::DiagWidth-1]     diagRdData
);
  import irPkg::*;

  logic                     irValid;
  logic                     irReady;
  irWordT                   irWord;
  logic                     jrst;
  logic                     enIoJrst;
  logic                     enAc;
  logic                     dispParityWord;
  logic [0:DramAddrWidth-1] dramAddr;

  irLatch latch_i (
    .eboxClk     (eboxClk),
    .arstN       (arstN),
    .instValid   (instValid),
    .instWord    (instWord),
    .instReady   (instReady),
    .irValid     (irValid),
    .irReady     (irReady),
    .irWord      (irWord),
    .jrst        (jrst),
    .jrst0       (jrst0),
    .ioLegal     (ioLegal),
    .acEq0       (acEq0),
    .irAc        (irAc),
    .diagCtlWe   (diagCtlWe),
    .diagCtlData (diagCtlData),
    .enIoJrst    (enIoJrst),
    .enAc        (enAc)
  );

  dramDispatch dispatch_i (
    .eboxClk        (eboxClk),
    .arstN          (arstN),
    .irValid        (irValid),
    .irReady        (irReady),
    .irWord         (irWord),
    .jrst           (jrst),
    .enIoJrst       (enIoJrst),
    .dispValid      (dispValid),
    .dispReady      (dispReady),
    .dispA          (dispA),
    .dispB          (dispB),
    .dispJHigh      (dispJHigh),
    .dispJLow       (dispJLow),
    .dispParityWord (dispParityWord),
    .dispParityOk   (dispParityOk),
    .dramAddr       (dramAddr),
    .diagWrEn       (diagWrEn),
    .diagWrAddr     (diagWrAddr),
    .diagWrData     (diagWrData)
  );

  // Condition test runs on the B field now in the output register
  condTest cond_i (
    .adData        (adData),
    .adCarry       (adCarry),
    .magicGt       (magicGt),
    .magicLt       (magicLt),
    .dispB         (dispB),
    .adEq0         (adEq0),
    .testSatisfied (testSatisfied),
    .norm          (norm)
  );

  diagRead diag_i (
    .diagSel        (diagSel),
    .norm           (norm),
    .dramAddr       (dramAddr),
    .enIoJrst       (enIoJrst),
    .enAc           (enAc),
    .irAc           (irAc),
    .dispA          (dispA),
    .dispB          (dispB),
    .testSatisfied  (testSatisfied),
    .jrst0          (jrst0),
    .dispJHigh      (dispJHigh),
    .dispParityWord (dispParityWord),
    .dispParityOk   (dispParityOk),
    .dispJLow       (dispJLow),
    .adEq0          (adEq0),
    .ioLegal        (ioLegal),
    .acEq0          (acEq0),
    .adCarry        (adCarry),
    .magicGt        (magicGt),
    .magicLt        (magicLt),
    .irWord         (irWord),
    .diagRdData     (diagRdData)
  );

endmodule

`default_nettype wire

/* tb/irBoardTb.sv */
`timescale 1ns/1ps
`default_nettype none

module irBoardTb;
  import irPkg::*;

  logic         eboxClk;
  logic         arstN;
  logic         instValid;
  logic [12:0]  instWord;
  logic         instReady;
  logic         dispValid;
  logic         dispReady;
  logic [2:0]   dispA;
  logic [2:0]   dispB;
  logic [3:0]   dispJHigh;
  logic [3:0]   dispJLow;
  logic         dispParityOk;
  logic [35:0]  adData;
  logic         adCarry;
  logic         magicGt;
  logic         magicLt;
  logic [3:0]   irAc;
  logic         ioLegal;
  logic         acEq0;
  logic         jrst0;
  logic         adEq0;
  logic         testSatisfied;
  logic [2:0]   norm;
  logic         diagWrEn;
  logic [8:0]   diagWrAddr;
  logic [14:0]  diagWrData;
  logic         diagCtlWe;
  logic [1:0]   diagCtlData;
  logic [2:0]   diagSel;
  logic [5:0]   diagRdData;

  // Golden records laid out as noted at the top of the hex file
  logic [107:0] golden [0:63];
  int           numRam;
  int           numStim;
  int           stimBase;

  irBoard dut_i (
    .eboxClk(eboxClk), .arstN(arstN),
    .instValid(instValid), .instWord(instWord), .instReady(instReady),
    .dispValid(dispValid), .dispReady(dispReady),
    .dispA(dispA), .dispB(dispB), .dispJHigh(dispJHigh), .dispJLow(dispJLow),
    .dispParityOk(dispParityOk),
    .adData(adData), .adCarry(adCarry), .magicGt(magicGt), .magicLt(magicLt),
    .irAc(irAc), .ioLegal(ioLegal), .acEq0(acEq0), .jrst0(jrst0),
    .adEq0(adEq0), .testSatisfied(testSatisfied), .norm(norm),
    .diagWrEn(diagWrEn), .diagWrAddr(diagWrAddr), .diagWrData(diagWrData),
    .diagCtlWe(diagCtlWe), .diagCtlData(diagCtlData),
    .diagSel(diagSel), .diagRdData(diagRdData)
  );

  initial begin
    eboxClk = 1'b0;
    forever #4 eboxClk = ~eboxClk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    if (got !== exp) begin
      failRun($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Readback groups built from the expected fields of one record
  function automatic logic [5:0] expectedDiag(input int sel, input logic [107:0] rec);
    logic [5:0] d;
    case (sel)
      0: d = {rec[2:0], rec[24:22]};
      1: d = rec[21:16];
      2: d = {rec[89:88], rec[15:12]};
      3: d = {rec[46:44], rec[42:40]};
      4: d = {rec[4], rec[8], rec[39:36]};
      5: d = {rec[29], rec[28], rec[35:32]};
      6: d = {rec[87:52] == 36'd0, rec[10], rec[9], rec[50:48]};
      default: d = rec[104:99];
    endcase
    return d;
  endfunction

  task automatic checkDispatch(input logic [107:0] rec);
    checkValue("dispA", 64'(dispA), 64'(rec[46:44]));
    checkValue("dispB", 64'(dispB), 64'(rec[42:40]));
    checkValue("dispJHigh", 64'(dispJHigh), 64'(rec[39:36]));
    checkValue("dispJLow", 64'(dispJLow), 64'(rec[35:32]));
    checkValue("dispParityOk", 64'(dispParityOk), 64'(rec[28]));
  endtask

  task automatic waitInstReady();
    int n;
    n = 0;
    forever begin
      @(negedge eboxClk);
      if (instReady) break;
      n++;
      if (n > 50) failRun("timed out waiting for instReady");
    end
  endtask

  task automatic waitDispValid(input logic level);
    int n;
    n = 0;
    forever begin
      @(negedge eboxClk);
      if (dispValid == level) break;
      n++;
      if (n > 50) failRun("timed out waiting for dispValid to change");
    end
  endtask

  task automatic writeCtl(input logic [1:0] ctl);
    @(posedge eboxClk);
    diagCtlWe   <= 1'b1;
    diagCtlData <= ctl;
    @(posedge eboxClk);
    diagCtlWe   <= 1'b0;
  endtask

  task automatic loadRam();
    logic [107:0] rec;
    logic [0:14]  word;
    for (int i = 0; i < numRam; i++) begin
      rec = golden[1 + i];
      word = '0;
      word[DramPosA +: 3]     = rec[18:16];
      word[DramPosB +: 3]     = rec[14:12];
      word[DramPosPar]        = rec[8];
      word[DramPosJHigh +: 4] = rec[7:4];
      word[DramPosJLow +: 4]  = rec[3:0];
      @(posedge eboxClk);
      diagWrEn   <= 1'b1;
      diagWrAddr <= rec[28:20];
      diagWrData <= word;
    end
    @(posedge eboxClk);
    diagWrEn <= 1'b0;
  endtask

  // One instruction at a time while the output is held for readback
  task automatic directedRecord(input logic [107:0] rec);
    writeCtl(rec[89:88]);
    adData    <= rec[87:52];
    adCarry   <= rec[50];
    magicGt   <= rec[49];
    magicLt   <= rec[48];
    instValid <= 1'b1;
    instWord  <= rec[104:92];
    waitInstReady();
    @(posedge eboxClk);
    instValid <= 1'b0;
    waitDispValid(1'b1);
    checkDispatch(rec);
    checkValue("irAc", 64'(irAc), 64'(rec[15:12]));
    checkValue("ioLegal", 64'(ioLegal), 64'(rec[10]));
    checkValue("acEq0", 64'(acEq0), 64'(rec[9]));
    checkValue("jrst0", 64'(jrst0), 64'(rec[8]));
    checkValue("adEq0", 64'(adEq0), 64'(rec[87:52] == 36'd0));
    checkValue("testSatisfied", 64'(testSatisfied), 64'(rec[4]));
    checkValue("norm", 64'(norm), 64'(rec[2:0]));
    for (int s = 0; s < 8; s++) begin
      @(posedge eboxClk);
      diagSel <= 3'(s);
      @(negedge eboxClk);
      checkValue($sformatf("diagRdData[sel %0d]", s), 64'(diagRdData),
                 64'(expectedDiag(s, rec)));
    end
    @(posedge eboxClk);
    dispReady <= 1'b1;
    @(posedge eboxClk);
    dispReady <= 1'b0;
    waitDispValid(1'b0);
  endtask

  // Back-to-back traffic with random output stalls
  task automatic streamRecords();
    int  streamList[$];
    int  expected[$];
    int  sent;
    int  cycles;
    int  idx;
    logic accepted;
    logic [107:0] rec;
    writeCtl(2'b10);
    // I/O words that need enIoJrst clear stay out of the stream
    for (int p = 0; p < 3; p++) begin
      for (int r = 0; r < numStim; r++) begin
        rec = golden[stimBase + r];
        if (rec[89] || rec[104:102] != 3'b111) streamList.push_back(r);
      end
    end
    sent = 0;
    cycles = 0;
    while (sent < streamList.size() || expected.size() != 0) begin
      @(negedge eboxClk);
      if (dispValid && dispReady) begin
        if (expected.size() == 0) failRun("dispatch appeared with nothing outstanding");
        idx = expected.pop_front();
        checkDispatch(golden[stimBase + idx]);
      end
      accepted = instValid & instReady;
      if (accepted) begin
        expected.push_back(streamList[sent]);
        sent++;
      end
      @(posedge eboxClk);
      dispReady <= ($urandom_range(2, 0) != 0);
      if (instValid && !accepted) begin
        // Hold the word until it is taken
        instValid <= 1'b1;
      end else if (sent < streamList.size() && $urandom_range(3, 0) != 0) begin
        instValid <= 1'b1;
        instWord  <= golden[stimBase + streamList[sent]][104:92];
      end else begin
        instValid <= 1'b0;
      end
      cycles++;
      if (cycles > 2000) failRun("stream did not finish in time");
    end
    @(negedge eboxClk);
    checkValue("dispValid", 64'(dispValid), 64'd0);
  endtask

  initial begin
    #200000;
    failRun("simulation ran past its time limit");
  end

  initial begin
    void'($urandom(21));
    arstN       = 1'b0;
    instValid   = 1'b0;
    instWord    = '0;
    dispReady   = 1'b0;
    adData      = '0;
    adCarry     = 1'b0;
    magicGt     = 1'b0;
    magicLt     = 1'b0;
    diagWrEn    = 1'b0;
    diagWrAddr  = '0;
    diagWrData  = '0;
    diagCtlWe   = 1'b0;
    diagCtlData = '0;
    diagSel     = '0;
    $readmemh("tb/irGolden.hex", golden);
    numRam   = int'(golden[0][7:0]);
    numStim  = int'(golden[1 + numRam][7:0]);
    stimBase = numRam + 2;
    repeat (3) @(posedge eboxClk);
    arstN <= 1'b1;
    @(negedge eboxClk);
    checkValue("instReady", 64'(instReady), 64'd1);
    checkValue("dispValid", 64'(dispValid), 64'd0);
    loadRam();
    for (int r = 0; r < numStim; r++) begin
      directedRecord(golden[stimBase + r]);
    end
    streamRecords();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/irPkg.sv
rtl/dramMem.sv
rtl/irLatch.sv
rtl/dramDispatch.sv
rtl/condTest.sv
rtl/diagRead.sv
rtl/irBoard.sv
tb/irBoardTb.sv

/* Makefile */
# Verilator build and run for the IR board testbench

VERILATOR ?= verilator
TOP       ?= irBoardTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tb/irGolden.hex */
// RAM count, then RAM records: addr(3) A B par Jhigh Jlow
// Stim count, then records: inst(4) ctl adData(9) cgl A B Jh Jl par addr(3) irAc lflg ts norm
8
080_320A5
0B8_1503C
0AC_40179
1D5_6311E
1D1_040F0
1FA_56128
03C_71101
1F8_17144
9
0805_1_000000000_0_32A51_080_5010
0B80_0_800000000_1_153C1_0B8_0201
0AC0_1_008000000_4_40703_0AC_0314
0AC7_0_100000000_3_40773_0AC_0002
1D1D_2_002000000_6_631E3_1D5_0016
1D1D_0_000008000_0_04F01_1D1_0011
1CFA_3_000000000_7_56283_1FA_A000
03C2_1_010000000_6_71012_03C_2413
1FC0_2_000000001_0_17443_1F8_0611
